// ==== compile.f ====
common/pi_pkg.sv
rtl/pi_code_ingress.sv
rtl/ref_phase_gen.sv
phase_blender/phase_select.sv
phase_blender/phase_blender.sv
rtl/edge_egress.sv
rtl/pi_top.sv
tb/pi_properties.sv
tb/pi_tb.sv

// ==== Makefile ====
# Verilator flow for the phase interpolator testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build pi_tb with Verilator, run it, fail if the log reports a failure"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module pi_tb -Mdir obj_dir -f compile.f
	./obj_dir/Vpi_tb +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	@if grep -q "Test failed" sim.log || ! grep -q "Test passed" sim.log; then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log

// ==== tb/pi_tb.sv ====
module pi_tb import pi_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DRV          = 1;    // ns after the rising edge
  localparam int WAIT_CREDIT  = 64;   // cycles a code may wait for a credit
  localparam int NUM_SWEEP    = 128;
  localparam int NUM_WRAP     = 48;   // three rounds of 112..127
  localparam int NUM_HOLD     = 12;
  localparam int NUM_RAND     = 64;
  localparam int CYC_PER_CODE = 24;   // worst case with random gaps
  localparam int TIMEOUT_NS   =
    100 * ((NUM_SWEEP + NUM_WRAP + NUM_HOLD + NUM_RAND) * CYC_PER_CODE + 300);

  logic        clk = 1'b0;
  logic        reset;
  logic        code_valid;
  phase_code_t code;
  logic        code_credit;
  logic        edge_valid;
  edge_time_t  edge_time;
  logic        edge_credit = 1'b0;

  edge_time_t exp_q[$];         // expected edges in send order
  int sent_total    = 0;        // codes accepted since reset
  int credits_spent = 0;        // upstream side
  int credits_back  = 0;
  int edges_seen    = 0;        // downstream side
  int credits_given = 0;
  int gap           = 0;        // cycles until the next edge_credit
  int max_delay     = 0;        // 0 gives prompt credits
  bit withhold      = 1'b0;     // downstream keeps its credits
  int errors = 0;
  int checks = 0;
  int err_base = 0;
  int chk_base = 0;
  int tests = 0;

  pi_top pi_top_i (
    .clk         (clk),
    .reset       (reset),
    .code_valid  (code_valid),
    .code        (code),
    .code_credit (code_credit),
    .edge_valid  (edge_valid),
    .edge_time   (edge_time),
    .edge_credit (edge_credit)
  );

  initial begin
    forever #50 clk = ~clk;
  end

  initial begin
    #(TIMEOUT_NS);
    $display("watchdog: run still busy after %0d ns, stopping", TIMEOUT_NS);
    $display("Test failed");
    $finish;
  end

  function automatic int up_credits();
    return CODE_FIFO_DEPTH - credits_spent + credits_back;
  endfunction

  // one period per code and 16 ps per code step
  function automatic edge_time_t expected_edge(int idx, phase_code_t c);
    return edge_time_t'(idx * REF_PERIOD + int'(c) * (PHASE_STEP / FINE_STEPS)
                        + BLEND_DELAY);
  endfunction

  // outputs sampled mid-cycle
  always @(negedge clk) begin
    edge_time_t exp;
    if (!reset) begin
      if (code_credit)
        credits_back++;
      if (edge_valid) begin
        edges_seen++;
        checks++;
        if (exp_q.size() == 0) begin
          $display("ERROR %0t: edge_valid with no code outstanding", $time);
          errors++;
        end else begin
          exp = exp_q.pop_front();
          assert (edge_time === exp) else begin
            $display("ERROR %0t: edge_time expected %h actual %h", $time, exp, edge_time);
            errors++;
          end
        end
      end
    end
  end

  // downstream model, one credit per retired edge
  always @(posedge clk) begin
    #DRV;
    edge_credit = 1'b0;
    if (gap != 0)
      gap--;
    else if (!reset && !withhold && edges_seen != credits_given) begin
      edge_credit = 1'b1;
      credits_given++;
      gap = (max_delay == 0) ? 0 : $urandom_range(max_delay, 0);
    end
  end

  // called at the drive point and returns there
  task automatic send_code(input phase_code_t c, output bit sent);
    int waited;
    waited = 0;
    while (up_credits() == 0 && waited < WAIT_CREDIT) begin
      @(posedge clk);
      #DRV;
      waited++;
    end
    sent = (up_credits() != 0);
    if (sent) begin
      code_valid = 1'b1;
      code       = c;
      credits_spent++;
      exp_q.push_back(expected_edge(sent_total, c));
      sent_total++;
      @(posedge clk);
      #DRV;
      code_valid = 1'b0;  // raised again at once by a back to back send
    end else if (!withhold) begin
      $display("%0t: code %0d never got an upstream credit", $time, c);
      errors++;
    end
  endtask

  task automatic expect_true(input bit cond, input string what);
    checks++;
    assert (cond) else begin
      $display("%0t: %s", $time, what);
      errors++;
    end
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0 || edges_seen != credits_given)
      @(posedge clk);
    repeat (4) @(posedge clk);  // last credit pulse lands
    #DRV;
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("%s: %0d checks, %0d errors", name, checks - chk_base, errors - err_base);
    chk_base = checks;
    err_base = errors;
  endtask

  initial begin
    bit ok;
    int n_hold;
    int held;
    int back0;
    int idle;
    void'($urandom(32'h31525d3a));
    reset      = 1'b1;
    code_valid = 1'b0;
    code       = '0;
    repeat (8) @(posedge clk);
    #DRV;
    reset = 1'b0;

    repeat (20) @(posedge clk);  // nothing sent yet
    #DRV;
    expect_true(edges_seen == 0, "edge_valid pulsed with no code sent");
    expect_true(credits_back == 0, "code_credit pulsed with no code sent");
    finish_test("reset_idle");

    for (int i = 0; i < NUM_SWEEP; i++)
      send_code(phase_code_t'(i), ok);
    wait_drain();
    finish_test("code_sweep");

    // coarse 7 blends into the next period and the base wraps every 32 codes
    for (int i = 0; i < NUM_WRAP; i++)
      send_code(phase_code_t'(112 + i % 16), ok);
    wait_drain();
    finish_test("phase_wrap");

    withhold = 1'b1;
    held     = edges_seen;
    n_hold   = 0;
    ok       = 1'b1;
    while (ok && n_hold < NUM_HOLD) begin
      send_code(phase_code_t'(n_hold * 11), ok);
      if (ok)
        n_hold++;
    end
    back0 = credits_back;
    repeat (10) @(posedge clk);
    #DRV;
    expect_true(edges_seen - held <= EDGE_CREDITS, "more edges sent than downstream credits");
    expect_true(up_credits() == 0, "upstream still holds credits, DUT never filled");
    expect_true(credits_back == back0, "code credits returned while the DUT was full");
    withhold = 1'b0;
    for (int i = n_hold; i < NUM_HOLD; i++)
      send_code(phase_code_t'(i * 11), ok);
    wait_drain();
    finish_test("backpressure");

    max_delay = 5;
    for (int i = 0; i < NUM_RAND; i++) begin
      idle = $urandom_range(3, 0);
      repeat (idle) begin
        @(posedge clk);
        #DRV;
      end
      send_code(phase_code_t'($urandom_range(127, 0)), ok);
    end
    wait_drain();
    finish_test("random");

    expect_true(credits_back == credits_spent, "code credits returned differ from codes sent");
    expect_true(up_credits() == CODE_FIFO_DEPTH, "upstream credits not back to full");
    finish_test("credit_balance");

    errors += pi_top_i.props_i.fail_reset + pi_top_i.props_i.fail_code
            + pi_top_i.props_i.fail_edge + pi_top_i.props_i.fail_x;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== tb/pi_properties.sv ====
module pi_properties import pi_pkg::*; (
  input logic       clk,
  input logic       reset,
  input logic       code_valid,
  input logic       code_credit,
  input logic       edge_valid,
  input edge_time_t edge_time,
  input logic       edge_credit
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned accepted;  // codes taken since reset
  int unsigned returned;  // code_credit pulses
  int unsigned sent;      // edge_valid pulses
  int unsigned retired;   // edge_credit pulses

  // failure counts per assertion
  int unsigned fail_reset = 0;
  int unsigned fail_code  = 0;
  int unsigned fail_edge  = 0;
  int unsigned fail_x     = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      accepted <= 0;
      returned <= 0;
      sent     <= 0;
      retired  <= 0;
    end else begin
      accepted <= accepted + 32'(code_valid);
      returned <= returned + 32'(code_credit);
      sent     <= sent + 32'(edge_valid);
      retired  <= retired + 32'(edge_credit);
    end
  end

  reset_quiet: assert property (@(posedge clk)
    (reset && $past(reset)) |-> (!code_credit && !edge_valid))
    else begin
      fail_reset++;
      $error("code_credit or edge_valid high during reset");
    end

  // a pop needs a code accepted on an earlier edge
  credit_bound: assert property (@(posedge clk) disable iff (reset)
    code_credit |-> (returned < accepted))
    else begin
      fail_code++;
      $error("more code credits returned than codes accepted");
    end

  edge_bound: assert property (@(posedge clk) disable iff (reset)
    edge_valid |-> (sent < EDGE_CREDITS + retired))
    else begin
      fail_edge++;
      $error("edge sent without a downstream credit");
    end

  edge_known: assert property (@(posedge clk) disable iff (reset)
    edge_valid |-> !$isunknown(edge_time))
    else begin
      fail_x++;
      $error("edge_time unknown while edge_valid is high");
    end

endmodule

bind pi_top pi_properties props_i (.*);

// ==== rtl/pi_top.sv ====
module pi_top import pi_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  // upstream loop
  input  logic        code_valid,
  input  phase_code_t code,
  output logic        code_credit,
  // downstream sampler
  output logic        edge_valid,
  output edge_time_t  edge_time,
  input  logic        edge_credit
);

  code_item_t   item;        // popped code
  logic         period_adv;  // base step per pop
  logic         slot_free;   // egress -> ingress slot return
  phase_edges_t edges;       // current period phases
  blend_pair_t  pair;        // selected pair and weight
  edge_item_t   blend_item;  // blended edge into the buffer

  pi_code_ingress u_ingress (
    .clk         (clk),
    .reset       (reset),
    .code_valid  (code_valid),
    .code        (code),
    .code_credit (code_credit),
    .slot_free   (slot_free),
    .item        (item),
    .period_adv  (period_adv)
  );

  ref_phase_gen u_ref_phase (
    .clk        (clk),
    .reset      (reset),
    .period_adv (period_adv),
    .edges      (edges)
  );

  phase_select u_select (
    .clk   (clk),
    .reset (reset),
    .item  (item),
    .edges (edges),
    .pair  (pair)
  );

  phase_blender u_blender (
    .clk      (clk),
    .reset    (reset),
    .pair     (pair),
    .out_item (blend_item)
  );

  edge_egress u_egress (
    .clk         (clk),
    .reset       (reset),
    .in_item     (blend_item),
    .edge_valid  (edge_valid),
    .edge_time   (edge_time),
    .edge_credit (edge_credit),
    .slot_free   (slot_free)
  );

endmodule

// ==== rtl/edge_egress.sv ====
module edge_egress import pi_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  edge_item_t in_item,      // from phase_blender with its slot reserved
  output logic       edge_valid,   // one cycle per edge
  output edge_time_t edge_time,
  input  logic       edge_credit,  // downstream retired an edge
  output logic       slot_free     // slot released toward ingress
);

  edge_time_t             mem [EGRESS_DEPTH];
  logic [EGR_PTR_W-1:0]   wr_ptr;
  logic [EGR_PTR_W-1:0]   rd_ptr;
  logic [EGR_PTR_W:0]     fill;     // buffered edges
  credit_cnt_t            credits;  // downstream credits in hand
  logic                   send;

  // something to send and somewhere to send it
  assign send = (fill != '0) && (credits != '0);

  // write side with the slot reserved at the ingress pop
  always_ff @(posedge clk) begin
    if (in_item.valid) begin
      mem[wr_ptr] <= in_item.t;
    end
  end

  always_ff @(posedge clk) begin
    if (send) begin
      edge_time <= mem[rd_ptr];  // held until the next send
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      fill       <= '0;
      credits    <= credit_cnt_t'(EDGE_CREDITS);
      edge_valid <= 1'b0;
      slot_free  <= 1'b0;
    end else begin
      if (in_item.valid) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (send) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      fill       <= fill + (EGR_PTR_W+1)'(in_item.valid) - (EGR_PTR_W+1)'(send);
      credits    <= credits + credit_cnt_t'(edge_credit) - credit_cnt_t'(send);
      edge_valid <= send;
      slot_free  <= send;  // same edge as edge_valid
    end
  end

endmodule

// ==== phase_blender/phase_blender.sv ====
module phase_blender import pi_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  blend_pair_t pair,     // from phase_select
  output edge_item_t  out_item  // blended edge two cycles later
);

  // stage 1 comb
  edge_time_t fwd;          // late - early modulo 2^16
  logic       early_leads;
  edge_time_t diff_d;
  edge_time_t lead_d;
  blend_cnt_t cnt_d;

  // stage 1 regs
  logic       s1_valid;
  logic       s1_early_leads;
  edge_time_t s1_lead;
  edge_time_t s1_diff;
  blend_cnt_t s1_cnt;

  // stage 2
  logic [TIME_W+WEIGHT_W:0] prod;  // diff * cnt at full width
  edge_time_t weighted;
  edge_time_t offset;
  logic       s2_valid;
  edge_time_t s2_time;

  always_comb begin
    fwd         = pair.late - pair.early;
    early_leads = ~fwd[TIME_W-1];  // under half the range counts as ahead
    diff_d      = early_leads ? fwd : (pair.early - pair.late);
    lead_d      = early_leads ? pair.early : pair.late;
    cnt_d       = blend_cnt_t'($countones(pair.therm));  // linear weight
  end

  always_ff @(posedge clk) begin
    if (pair.valid) begin
      s1_early_leads <= early_leads;
      s1_lead        <= lead_d;
      s1_diff        <= diff_d;
      s1_cnt         <= cnt_d;
    end
  end

  // weight always pulls from the early input toward the late one
  always_comb begin
    prod     = (TIME_W+WEIGHT_W+1)'(s1_diff) * (TIME_W+WEIGHT_W+1)'(s1_cnt);
    weighted = edge_time_t'(prod / FINE_STEPS);  // exact for a 256 ps step
    // late input leading measures back from the far end of the gap
    offset   = s1_early_leads ? weighted : (s1_diff - weighted);
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      s2_time <= s1_lead + offset + edge_time_t'(BLEND_DELAY);
    end
  end

  // valid pipe
  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= pair.valid;
      s2_valid <= s1_valid;
    end
  end

  assign out_item = '{valid: s2_valid, t: s2_time};

endmodule

// ==== phase_blender/phase_select.sv ====
module phase_select import pi_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  code_item_t   item,   // code from ingress
  input  phase_edges_t edges,  // edges of the code's own period
  output blend_pair_t  pair    // registered pair and weight
);

  coarse_t    coarse;
  weight_t    fine;
  edge_time_t early_d;
  edge_time_t late_d;
  therm_t     therm_d;

  logic       valid_q;
  edge_time_t early_q;
  edge_time_t late_q;
  therm_t     therm_q;

  always_comb begin
    coarse  = item.code[CODE_W-1 -: COARSE_W];  // upper bits
    fine    = item.code[WEIGHT_W-1:0];          // lower bits
    early_d = edges[coarse];
    // last phase blends toward phase 0 of the following period
    if (coarse == coarse_t'(NUM_PHASES - 1)) begin
      late_d = edges[0] + edge_time_t'(REF_PERIOD);
    end else begin
      late_d = edges[coarse + 1'b1];
    end
    // fine ones in the low bits and weight 0 gives all zeros
    therm_d = (therm_t'(1) << fine) - therm_t'(1);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= item.valid;
    end
  end

  // payload only moves with a real code
  always_ff @(posedge clk) begin
    if (item.valid) begin
      early_q <= early_d;
      late_q  <= late_d;
      therm_q <= therm_d;
    end
  end

  assign pair = '{valid: valid_q, early: early_q, late: late_q, therm: therm_q};

endmodule

// ==== rtl/ref_phase_gen.sv ====
module ref_phase_gen import pi_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         period_adv,  // pulse per popped code
  output phase_edges_t edges        // phase edges of the current period
);

  edge_time_t base;  // rising edge of phase 0 wrapping at 64k ps

  // one period per code so the i-th code sees base i * REF_PERIOD
  always_ff @(posedge clk) begin
    if (reset) begin
      base <= '0;
    end else if (period_adv) begin
      base <= base + edge_time_t'(REF_PERIOD);  // modulo 2^16
    end
  end

  // evenly spaced phases
  // the popping code samples these before base moves on
  always_comb begin
    for (int k = 0; k < NUM_PHASES; k++) begin
      edges[k] = base + edge_time_t'(k * PHASE_STEP);
    end
  end

endmodule

// ==== rtl/pi_code_ingress.sv ====
module pi_code_ingress import pi_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        code_valid,   // spends one upstream credit
  input  phase_code_t code,
  output logic        code_credit,  // one pulse per pop
  input  logic        slot_free,    // egress released a slot
  output code_item_t  item,         // popped code valid for one cycle
  output logic        period_adv    // tells ref_phase_gen to step the base
);

  phase_code_t             mem [CODE_FIFO_DEPTH];  // code storage
  logic [CODE_PTR_W-1:0]   wr_ptr;
  logic [CODE_PTR_W-1:0]   rd_ptr;
  logic [CODE_PTR_W:0]     fill;   // entries held up to depth
  credit_cnt_t             slots;  // egress slots not yet reserved
  logic                    pop;

  // pop needs a code and a reserved slot
  assign pop = (fill != '0) && (slots != '0);

  assign code_credit = pop;  // entry freed so upstream may send again
  assign period_adv  = pop;  // each code owns one reference period
  assign item        = '{valid: pop, code: mem[rd_ptr]};

  // code storage
  always_ff @(posedge clk) begin
    if (code_valid) begin
      mem[wr_ptr] <= code;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      slots  <= credit_cnt_t'(EGRESS_DEPTH);  // every egress slot is free
    end else begin
      if (code_valid) begin
        wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps by itself
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // upstream credits keep fill within depth
      fill  <= fill + (CODE_PTR_W+1)'(code_valid) - (CODE_PTR_W+1)'(pop);
      // reserve on pop and release when egress sends
      slots <= slots + credit_cnt_t'(slot_free) - credit_cnt_t'(pop);
    end
  end

endmodule

// ==== common/pi_pkg.sv ====
package pi_pkg;

  // reference clock geometry in ps
  localparam int NUM_PHASES  = 8;     // phases per reference period
  localparam int PHASE_STEP  = 256;   // spacing of adjacent phases
  localparam int REF_PERIOD  = 2048;  // NUM_PHASES * PHASE_STEP
  localparam int FINE_STEPS  = 16;    // blend weight resolution
  localparam int BLEND_DELAY = 35;    // intrinsic blender delay

  // buffering and credits
  localparam int CODE_FIFO_DEPTH = 4;  // also the upstream credit grant
  localparam int EGRESS_DEPTH    = 4;  // also the internal slot credits
  localparam int EDGE_CREDITS    = 2;  // initial downstream credits

  // derived widths
  localparam int TIME_W     = 16;
  localparam int CODE_W     = 7;
  localparam int COARSE_W   = $clog2(NUM_PHASES);
  localparam int WEIGHT_W   = CODE_W - COARSE_W;
  localparam int CODE_PTR_W = $clog2(CODE_FIFO_DEPTH);
  localparam int EGR_PTR_W  = $clog2(EGRESS_DEPTH);

  typedef logic [TIME_W-1:0]        edge_time_t;   // ps timestamp wrapping at 64k
  typedef logic [CODE_W-1:0]        phase_code_t;  // {coarse, fine}
  typedef logic [COARSE_W-1:0]      coarse_t;      // selects phase pair k, k+1
  typedef logic [WEIGHT_W-1:0]      weight_t;      // fine blend weight
  typedef logic [FINE_STEPS-1:0]    therm_t;       // thermometer weight
  typedef logic [WEIGHT_W:0]        blend_cnt_t;   // ones in a therm_t up to 16
  typedef logic [3:0]               credit_cnt_t;  // credit and slot counters

  // entry k is the rising edge of phase k in the current period
  typedef edge_time_t [NUM_PHASES-1:0] phase_edges_t;

  // ingress -> phase_select
  typedef struct packed {
    logic        valid;
    phase_code_t code;
  } code_item_t;

  // phase_select -> phase_blender
  typedef struct packed {
    logic       valid;
    edge_time_t early;  // edge of phase k
    edge_time_t late;   // edge of phase k+1
    therm_t     therm;  // weight toward late
  } blend_pair_t;

  // phase_blender -> egress
  typedef struct packed {
    logic       valid;
    edge_time_t t;  // blended edge
  } edge_item_t;

endpackage
